// ==== csr_stage_defines.svh ====
`ifndef CSR_STAGE_DEFINES_SVH
`define CSR_STAGE_DEFINES_SVH

// Data width of the core
`define XLEN 32

// CSR address field width
`define CSR_ADDR_W 12

// Width of the cycle counter and the machine timer
`define CNT_W 64

// Privilege mode after reset, M mode
`define CSR_RESET_MODE 2'd3

`endif

// ==== csr_pkg.sv ====
`include "csr_stage_defines.svh"

package csr_pkg;

    // CSR addresses that are implemented
    typedef enum logic [`CSR_ADDR_W-1:0] {
        ADDR_CYCLE    = 12'hc00,
        ADDR_CYCLEH   = 12'hc80,
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344,
        ADDR_MCYCLE   = 12'hb00,
        ADDR_MCYCLEH  = 12'hb80
    } csr_addr_e;

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [1:0] {
        MODE_U = 2'd0,
        MODE_M = 2'd3
    } mode_e;

    typedef enum logic [1:0] {
        XTVEC_DIRECT   = 2'd0,
        XTVEC_VECTORED = 2'd1
    } xtvec_mode_e;

    // MXL = 1, extensions I and M
    localparam logic [31:0] MISA_VALUE = 32'h4000_1100;

endpackage

// ==== trap_pkg.sv ====
`include "csr_stage_defines.svh"

package trap_pkg;

    // Exception causes
    localparam logic [`XLEN-1:0] CAUSE_ECALL_FROM_U = 32'd8;
    localparam logic [`XLEN-1:0] CAUSE_ECALL_FROM_M = 32'd11;

    // Machine interrupts carry the top bit
    localparam logic [`XLEN-1:0] CAUSE_M_SOFT_IRQ  = 32'h8000_0003;
    localparam logic [`XLEN-1:0] CAUSE_M_TIMER_IRQ = 32'h8000_0007;
    localparam logic [`XLEN-1:0] CAUSE_M_EXT_IRQ   = 32'h8000_000b;

    // One bit per machine interrupt source, for pending and enable sets
    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_bits_t;

    // Exception raised by an earlier stage
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] cause;
    } trap_info_t;

endpackage

// ==== csr_if.sv ====
`timescale 1ns/1ps
`include "csr_stage_defines.svh"

// Write port into the register file and its read view
interface csr_rw_if import csr_pkg::*; ();
    logic             wr_en;
    csr_addr_e        wr_addr;
    logic [`XLEN-1:0] wr_data;

    logic [`XLEN-1:0] mstatus_word;
    logic [`XLEN-1:0] mie_word;
    logic [`XLEN-1:0] mip_word;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;

    modport access (
        output wr_en, wr_addr, wr_data,
        input  mstatus_word, mie_word, mip_word, mtvec, mscratch, mepc, mcause
    );

    modport regs (
        input  wr_en, wr_addr, wr_data,
        output mstatus_word, mie_word, mip_word, mtvec, mscratch, mepc, mcause
    );
endinterface

// Trap state out of the register file and the trap decision back into it
interface trap_if import csr_pkg::*, trap_pkg::*; ();
    mode_e            mode;
    logic             mstatus_mie;
    irq_bits_t        irq_pending;
    irq_bits_t        irq_enable;
    logic [`XLEN-1:0] mtvec;
    // A trap was committed at the end of the last first cycle
    logic             trap_taken;

    logic             take_trap;
    logic             is_interrupt;
    logic [`XLEN-1:0] trap_cause;
    logic [`XLEN-1:0] trap_target;

    modport regs (
        output mode, mstatus_mie, irq_pending, irq_enable, mtvec, trap_taken,
        input  take_trap, is_interrupt, trap_cause, trap_target
    );

    modport ctrl (
        input  mode, mstatus_mie, irq_pending, irq_enable, mtvec, trap_taken,
        output take_trap, is_interrupt, trap_cause, trap_target
    );
endinterface

// ==== csr_access.sv ====
`timescale 1ns/1ps
`include "csr_stage_defines.svh"

module csr_access import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  logic                   is_new,
    input  csr_cmd_e               csr_cmd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`XLEN-1:0]       op1_data,
    input  logic [`CNT_W-1:0]      reg_cycle,
    input  mode_e                  mode,
    input  logic                   take_trap,
    csr_rw_if.access               regs,
    output logic [`XLEN-1:0]       next_csr_rdata
);

    logic             can_read;
    logic             can_write;
    logic             cmd_is_write;
    logic [`XLEN-1:0] rdata_raw;
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] wdata;
    logic [`XLEN-1:0] rdata_saved;

    // Bits 9:8 give the lowest mode allowed, bits 11:10 == 3 mark read-only
    assign can_read  = csr_addr[9:8] <= mode;
    assign can_write = can_read && (csr_addr[11:10] != 2'b11);

    assign cmd_is_write = (csr_cmd == CSR_W) || (csr_cmd == CSR_S) || (csr_cmd == CSR_C);

    always_comb begin
        case (csr_addr)
            ADDR_CYCLE,
            ADDR_MCYCLE:   rdata_raw = reg_cycle[31:0];
            ADDR_CYCLEH,
            ADDR_MCYCLEH:  rdata_raw = reg_cycle[63:32];
            ADDR_MSTATUS:  rdata_raw = regs.mstatus_word;
            ADDR_MISA:     rdata_raw = MISA_VALUE;
            ADDR_MIE:      rdata_raw = regs.mie_word;
            ADDR_MTVEC:    rdata_raw = regs.mtvec;
            ADDR_MSCRATCH: rdata_raw = regs.mscratch;
            ADDR_MEPC:     rdata_raw = regs.mepc;
            ADDR_MCAUSE:   rdata_raw = regs.mcause;
            ADDR_MIP:      rdata_raw = regs.mip_word;
            default:       rdata_raw = '0;
        endcase
    end

    // Denied reads return zero
    assign rdata = can_read ? rdata_raw : '0;

    // Read-modify-write value
    always_comb begin
        case (csr_cmd)
            CSR_W:   wdata = op1_data;
            CSR_S:   wdata = rdata | op1_data;
            CSR_C:   wdata = rdata & ~op1_data;
            default: wdata = '0;
        endcase
    end

    // Write commits in the second cycle only
    assign regs.wr_en   = valid && !is_new && cmd_is_write && can_write;
    assign regs.wr_addr = csr_addr_e'(csr_addr);
    assign regs.wr_data = wdata;

    // Old value is captured before any write lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_saved <= '0;
        end else if (valid && is_new && !take_trap) begin
            rdata_saved <= rdata;
        end
    end

    assign next_csr_rdata = rdata_saved;

    // A write is always the second half of a two-cycle instruction
    a_wr_after_first: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs.wr_en |-> !is_new && $past(valid && is_new)
    );

endmodule

// ==== csr_machine_regs.sv ====
`timescale 1ns/1ps
`include "csr_stage_defines.svh"

module csr_machine_regs import csr_pkg::*, trap_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  logic              is_new,
    input  csr_cmd_e          csr_cmd,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`CNT_W-1:0] reg_mtime,
    input  logic [`CNT_W-1:0] reg_mtimecmp,
    csr_rw_if.regs            rw,
    trap_if.regs              trap,
    output logic [`XLEN-1:0]  trap_vector
);

    mode_e            cur_mode;
    mode_e            mpp;
    logic             mpie;
    logic             mstatus_mie;
    irq_bits_t        irq_en;
    irq_bits_t        irq_pend;
    irq_bits_t        irq_active;
    irq_bits_t        irq_clear;
    logic             trap_taken;
    logic [`XLEN-1:0] mtvec_r;
    logic [`XLEN-1:0] mscratch_r;
    logic [`XLEN-1:0] mepc_r;
    logic [`XLEN-1:0] mcause_r;
    logic [`XLEN-1:0] trap_vector_r;

    assign irq_active = irq_pend & irq_en;

    // Source that an interrupt trap acknowledges, MEI first
    always_comb begin
        irq_clear = '0;
        if (irq_active.meip) begin
            irq_clear.meip = 1'b1;
        end else if (irq_active.msip) begin
            irq_clear.msip = 1'b1;
        end else if (irq_active.mtip) begin
            irq_clear.mtip = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_mode      <= mode_e'(`CSR_RESET_MODE);
            mpp           <= MODE_M;
            mpie          <= 1'b0;
            mstatus_mie   <= 1'b0;
            irq_en        <= '0;
            irq_pend      <= '0;
            trap_taken    <= 1'b0;
            mtvec_r       <= '0;
            mscratch_r    <= '0;
            mepc_r        <= '0;
            mcause_r      <= '0;
            trap_vector_r <= '1;
        end else begin
            if (valid && is_new) begin
                trap_taken <= trap.take_trap;
                if (trap.take_trap) begin
                    cur_mode      <= MODE_M;
                    mpp           <= cur_mode;
                    mpie          <= mstatus_mie;
                    mstatus_mie   <= 1'b0;
                    mepc_r        <= pc;
                    mcause_r      <= trap.trap_cause;
                    trap_vector_r <= trap.trap_target;
                    if (trap.is_interrupt) begin
                        irq_pend <= irq_bits_t'(irq_pend & ~irq_clear);
                    end
                end else begin
                    irq_pend.mtip <= reg_mtime >= reg_mtimecmp;
                    if (csr_cmd == CSR_MRET) begin
                        cur_mode      <= mpp;
                        mstatus_mie   <= mpie;
                        mpie          <= 1'b1;
                        mpp           <= MODE_U;
                        trap_vector_r <= mepc_r;
                    end else begin
                        // No redirect
                        trap_vector_r <= '1;
                    end
                end
            end
            if (rw.wr_en) begin
                case (rw.wr_addr)
                    ADDR_MSTATUS: begin
                        // Only U and M are legal for mpp
                        mpp         <= (rw.wr_data[12:11] == MODE_U) ? MODE_U : MODE_M;
                        mpie        <= rw.wr_data[7];
                        mstatus_mie <= rw.wr_data[3];
                    end
                    ADDR_MIE: begin
                        irq_en.meip <= rw.wr_data[11];
                        irq_en.mtip <= rw.wr_data[7];
                        irq_en.msip <= rw.wr_data[3];
                    end
                    ADDR_MIP: begin
                        // mtip follows the timer compare
                        irq_pend.meip <= rw.wr_data[11];
                        irq_pend.msip <= rw.wr_data[3];
                    end
                    ADDR_MTVEC:    mtvec_r    <= rw.wr_data;
                    ADDR_MSCRATCH: mscratch_r <= rw.wr_data;
                    ADDR_MEPC:     mepc_r     <= {rw.wr_data[`XLEN-1:2], 2'b00};
                    ADDR_MCAUSE:   mcause_r   <= rw.wr_data;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign rw.mstatus_word = {19'b0, mpp, 3'b0, mpie, 3'b0, mstatus_mie, 3'b0};
    assign rw.mie_word     = {20'b0, irq_en.meip, 3'b0, irq_en.mtip, 3'b0, irq_en.msip, 3'b0};
    assign rw.mip_word     = {20'b0, irq_pend.meip, 3'b0, irq_pend.mtip, 3'b0,
                              irq_pend.msip, 3'b0};
    assign rw.mtvec        = mtvec_r;
    assign rw.mscratch     = mscratch_r;
    assign rw.mepc         = mepc_r;
    assign rw.mcause       = mcause_r;

    assign trap.mode        = cur_mode;
    assign trap.mstatus_mie = mstatus_mie;
    assign trap.irq_pending = irq_pend;
    assign trap.irq_enable  = irq_en;
    assign trap.mtvec       = mtvec_r;
    assign trap.trap_taken  = trap_taken;

    assign trap_vector = trap_vector_r;

    // Mode stays legal through traps, MRET and mstatus writes
    a_mode_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        cur_mode inside {MODE_M, MODE_U}
    );

    // Acknowledged source is pending, enabled and matches the chosen cause
    a_irq_ack_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid && is_new && trap.take_trap && trap.is_interrupt |->
            (irq_clear.meip && trap.trap_cause == CAUSE_M_EXT_IRQ) ||
            (irq_clear.msip && trap.trap_cause == CAUSE_M_SOFT_IRQ) ||
            (irq_clear.mtip && trap.trap_cause == CAUSE_M_TIMER_IRQ)
    );

endmodule

// ==== trap_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_stage_defines.svh"

module trap_ctrl import csr_pkg::*, trap_pkg::*; (
    input  logic       valid,
    input  logic       is_new,
    input  csr_cmd_e   csr_cmd,
    input  trap_info_t trap_info,
    trap_if.ctrl       trap,
    output logic       is_stall,
    output logic       csr_is_trap
);

    irq_bits_t        irq_active;
    logic             global_mie;
    logic             may_interrupt;
    logic             may_trap;
    logic             cmd_is_ecall;
    logic             cmd_is_trap;
    logic             cmd_is_write;
    logic [`XLEN-1:0] irq_cause;
    logic [`XLEN-1:0] expt_cause;
    logic [`XLEN-1:0] ecall_cause;
    logic [`XLEN-1:0] tvec_base;

    assign irq_active = trap.irq_pending & trap.irq_enable;

    // U mode always takes machine interrupts
    assign global_mie    = (trap.mode == MODE_U) || trap.mstatus_mie;
    assign may_interrupt = global_mie && (|irq_active);

    always_comb begin
        if (irq_active.meip) begin
            irq_cause = CAUSE_M_EXT_IRQ;
        end else if (irq_active.msip) begin
            irq_cause = CAUSE_M_SOFT_IRQ;
        end else begin
            irq_cause = CAUSE_M_TIMER_IRQ;
        end
    end

    // ECALL cause depends on the mode it came from
    assign ecall_cause = CAUSE_ECALL_FROM_U + {{(`XLEN-2){1'b0}}, trap.mode};
    assign expt_cause  = (trap_info.cause == CAUSE_ECALL_FROM_U) ? ecall_cause
                                                                 : trap_info.cause;

    assign cmd_is_ecall = csr_cmd == CSR_ECALL;
    assign cmd_is_trap  = cmd_is_ecall || (csr_cmd == CSR_MRET);
    assign cmd_is_write = (csr_cmd == CSR_W) || (csr_cmd == CSR_S) || (csr_cmd == CSR_C);

    assign may_trap = trap_info.valid || may_interrupt;

    // Exceptions win over interrupts
    assign trap.take_trap    = valid && (may_trap || cmd_is_ecall);
    assign trap.is_interrupt = valid && !trap_info.valid && !cmd_is_ecall && may_interrupt;

    always_comb begin
        if (trap_info.valid) begin
            trap.trap_cause = expt_cause;
        end else if (cmd_is_ecall) begin
            trap.trap_cause = ecall_cause;
        end else begin
            trap.trap_cause = irq_cause;
        end
    end

    assign tvec_base = {trap.mtvec[`XLEN-1:2], 2'b00};

    // Vectored interrupts land at base + 4 * code
    always_comb begin
        if (trap.is_interrupt && (xtvec_mode_e'(trap.mtvec[1:0]) == XTVEC_VECTORED)) begin
            trap.trap_target = tvec_base + {trap.trap_cause[`XLEN-3:0], 2'b00};
        end else begin
            trap.trap_target = tvec_base;
        end
    end

    assign is_stall    = valid && is_new && (may_trap || cmd_is_trap || cmd_is_write);
    assign csr_is_trap = valid && !is_new && (may_trap || trap.trap_taken || cmd_is_trap);

endmodule

// ==== csr_stage_top.sv ====
`timescale 1ns/1ps
`include "csr_stage_defines.svh"

module csr_stage_top import csr_pkg::*, trap_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  logic                   is_new,
    input  logic                   trap_valid,
    input  logic [`XLEN-1:0]       trap_cause,
    input  logic [`XLEN-1:0]       pc,
    input  csr_cmd_e               csr_cmd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`XLEN-1:0]       op1_data,
    input  logic [`CNT_W-1:0]      reg_cycle,
    input  logic [`CNT_W-1:0]      reg_mtime,
    input  logic [`CNT_W-1:0]      reg_mtimecmp,
    output logic [`XLEN-1:0]       next_csr_rdata,
    output logic                   is_stall,
    output logic                   csr_is_trap,
    output logic [`XLEN-1:0]       csr_trap_vector,
    output mode_e                  output_mode
);

    trap_info_t trap_info;

    csr_rw_if rw_bus ();
    trap_if   trap_bus ();

    assign trap_info   = {trap_valid, trap_cause};
    assign output_mode = trap_bus.mode;

    csr_access access_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (valid),
        .is_new         (is_new),
        .csr_cmd        (csr_cmd),
        .csr_addr       (csr_addr),
        .op1_data       (op1_data),
        .reg_cycle      (reg_cycle),
        .mode           (trap_bus.mode),
        .take_trap      (trap_bus.take_trap),
        .regs           (rw_bus.access),
        .next_csr_rdata (next_csr_rdata)
    );

    csr_machine_regs regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .is_new       (is_new),
        .csr_cmd      (csr_cmd),
        .pc           (pc),
        .reg_mtime    (reg_mtime),
        .reg_mtimecmp (reg_mtimecmp),
        .rw           (rw_bus.regs),
        .trap         (trap_bus.regs),
        .trap_vector  (csr_trap_vector)
    );

    trap_ctrl trap_ctrl_i (
        .valid       (valid),
        .is_new      (is_new),
        .csr_cmd     (csr_cmd),
        .trap_info   (trap_info),
        .trap        (trap_bus.ctrl),
        .is_stall    (is_stall),
        .csr_is_trap (csr_is_trap)
    );

endmodule

// ==== tb_csr_stage.sv ====
`timescale 1ns/1ps
`include "csr_stage_defines.svh"

module tb_csr_stage import csr_pkg::*; ();

    // Tests take about 85 cycles, the limit leaves a wide margin
    localparam int MAX_CYCLES = 400;

    logic                   clk;
    logic                   rst_n;
    logic                   valid;
    logic                   is_new;
    logic                   trap_valid;
    logic [`XLEN-1:0]       trap_cause;
    logic [`XLEN-1:0]       pc;
    csr_cmd_e               csr_cmd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       op1_data;
    logic [`CNT_W-1:0]      reg_cycle;
    logic [`CNT_W-1:0]      reg_mtime;
    logic [`CNT_W-1:0]      reg_mtimecmp;
    logic [`XLEN-1:0]       next_csr_rdata;
    logic                   is_stall;
    logic                   csr_is_trap;
    logic [`XLEN-1:0]       csr_trap_vector;
    mode_e                  output_mode;

    logic [15:0]      lfsr_state;
    int               cycle_count;
    logic             first_stall;
    logic             second_trap;
    logic [`XLEN-1:0] second_vector;

    csr_stage_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid           (valid),
        .is_new          (is_new),
        .trap_valid      (trap_valid),
        .trap_cause      (trap_cause),
        .pc              (pc),
        .csr_cmd         (csr_cmd),
        .csr_addr        (csr_addr),
        .op1_data        (op1_data),
        .reg_cycle       (reg_cycle),
        .reg_mtime       (reg_mtime),
        .reg_mtimecmp    (reg_mtimecmp),
        .next_csr_rdata  (next_csr_rdata),
        .is_stall        (is_stall),
        .csr_is_trap     (csr_is_trap),
        .csr_trap_vector (csr_trap_vector),
        .output_mode     (output_mode)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic fail_value(input string name, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        abort_run();
    endtask

    task automatic fail_event(input string what);
        $display("Error: %s", what);
        abort_run();
    endtask

    task automatic expect_word(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        word_match: assert (actual === expected)
            else fail_value(name, expected, actual);
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_word(output logic [`XLEN-1:0] word);
        word = '0;
        for (int i = 0; i < `XLEN; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word = {word[`XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // One instruction, first cycle then second cycle, then idle
    task automatic run_instr(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`XLEN-1:0] operand);
        @(negedge clk);
        valid    = 1'b1;
        is_new   = 1'b1;
        csr_cmd  = cmd;
        csr_addr = addr;
        op1_data = operand;
        #1;
        first_stall = is_stall;
        @(negedge clk);
        is_new = 1'b0;
        #1;
        second_trap   = csr_is_trap;
        second_vector = csr_trap_vector;
        @(negedge clk);
        valid   = 1'b0;
        csr_cmd = CSR_NONE;
    endtask

    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr);
        run_instr(CSR_NONE, addr, '0);
    endtask

    quiet_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !valid |-> !is_stall && !csr_is_trap
    ) else fail_event("is_stall or csr_is_trap was high with no instruction present");

    stall_on_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid && is_new && (csr_cmd inside {CSR_W, CSR_S, CSR_C}) |-> is_stall
    ) else fail_event("a CSR write did not stall in its first cycle");

    stall_first_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_stall |-> is_new
    ) else fail_event("is_stall was high outside the first cycle");

    // No redirect means the vector register holds all ones
    vector_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid && !is_new && !csr_is_trap |-> csr_trap_vector == '1
    ) else fail_value("vector_idle", '1, $sampled(csr_trap_vector));

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        abort_run();
    end

    initial begin
        logic [`XLEN-1:0] scratch_val;
        logic [`XLEN-1:0] mask_s;
        logic [`XLEN-1:0] mask_c;
        logic [`XLEN-1:0] tvec_base;
        logic [`XLEN-1:0] tvec_vec;
        logic [`XLEN-1:0] ecall_pc;
        logic [`XLEN-1:0] u_pc;
        logic [`XLEN-1:0] irq_pc;
        logic [`XLEN-1:0] junk;

        rst_n        = 1'b0;
        valid        = 1'b0;
        is_new       = 1'b0;
        trap_valid   = 1'b0;
        trap_cause   = '0;
        pc           = 32'h0000_0100;
        csr_cmd      = CSR_NONE;
        csr_addr     = '0;
        op1_data     = '0;
        reg_cycle    = 64'h0123_4567_89ab_cdef;
        reg_mtime    = '0;
        reg_mtimecmp = 64'h0000_0000_0000_1000;
        lfsr_state   = 16'd19955;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // CSRRW on mscratch, old value first
        draw_word(scratch_val);
        run_instr(CSR_W, ADDR_MSCRATCH, scratch_val);
        expect_word("rw_old_value", 32'h0, next_csr_rdata);
        read_csr(ADDR_MSCRATCH);
        expect_word("rw_readback", scratch_val, next_csr_rdata);
        read_csr(ADDR_CYCLEH);
        expect_word("cycleh_read", reg_cycle[63:32], next_csr_rdata);

        // CSRRS then CSRRC with random masks
        draw_word(mask_s);
        draw_word(mask_c);
        run_instr(CSR_S, ADDR_MSCRATCH, mask_s);
        expect_word("rs_old_value", scratch_val, next_csr_rdata);
        run_instr(CSR_C, ADDR_MSCRATCH, mask_c);
        expect_word("rc_old_value", scratch_val | mask_s, next_csr_rdata);
        scratch_val = (scratch_val | mask_s) & ~mask_c;
        read_csr(ADDR_MSCRATCH);
        expect_word("rc_readback", scratch_val, next_csr_rdata);

        // ECALL from M, direct mtvec
        draw_word(tvec_base);
        tvec_base = tvec_base & ~32'h3;
        run_instr(CSR_W, ADDR_MTVEC, tvec_base);
        draw_word(ecall_pc);
        ecall_pc = ecall_pc & ~32'h3;
        pc = ecall_pc;
        run_instr(CSR_ECALL, ADDR_MSCRATCH, '0);
        expect_word("ecall_m_stall", 32'd1, first_stall);
        expect_word("ecall_m_trap", 32'd1, second_trap);
        expect_word("ecall_m_vector", tvec_base, second_vector);
        read_csr(ADDR_MCAUSE);
        expect_word("ecall_m_mcause", 32'd11, next_csr_rdata);
        read_csr(ADDR_MEPC);
        expect_word("ecall_m_mepc", ecall_pc, next_csr_rdata);

        // MRET with mpp = U
        run_instr(CSR_W, ADDR_MSTATUS, 32'h0);
        run_instr(CSR_MRET, ADDR_MSCRATCH, '0);
        expect_word("mret_trap", 32'd1, second_trap);
        expect_word("mret_vector", ecall_pc, second_vector);
        expect_word("mret_mode", 32'd0, 32'(output_mode));
        read_csr(ADDR_MSCRATCH);
        expect_word("u_mscratch_read", 32'h0, next_csr_rdata);
        read_csr(ADDR_CYCLE);
        expect_word("u_cycle_read", reg_cycle[31:0], next_csr_rdata);
        draw_word(junk);
        run_instr(CSR_W, ADDR_MSCRATCH, junk);

        // Back to M through ECALL from U
        draw_word(u_pc);
        u_pc = u_pc & ~32'h3;
        pc = u_pc;
        run_instr(CSR_ECALL, ADDR_MSCRATCH, '0);
        expect_word("ecall_u_vector", tvec_base, second_vector);
        expect_word("ecall_u_mode", 32'd3, 32'(output_mode));
        read_csr(ADDR_MCAUSE);
        expect_word("ecall_u_mcause", 32'd8, next_csr_rdata);
        read_csr(ADDR_MSCRATCH);
        expect_word("u_write_dropped", scratch_val, next_csr_rdata);

        // Timer interrupt, vectored mtvec
        draw_word(tvec_vec);
        tvec_vec = tvec_vec & ~32'h3;
        run_instr(CSR_W, ADDR_MTVEC, tvec_vec | 32'h1);
        run_instr(CSR_W, ADDR_MIE, 32'h0000_0080);
        run_instr(CSR_W, ADDR_MSTATUS, 32'h0000_0008);
        reg_mtime = reg_mtimecmp + 64'd5;
        read_csr(ADDR_MIP);
        expect_word("mip_before_refresh", 32'h0, next_csr_rdata);
        draw_word(irq_pc);
        irq_pc = irq_pc & ~32'h3;
        pc = irq_pc;
        read_csr(ADDR_MSCRATCH);
        expect_word("irq_stall", 32'd1, first_stall);
        expect_word("irq_trap", 32'd1, second_trap);
        expect_word("irq_vector", tvec_vec + 32'd28, second_vector);
        read_csr(ADDR_MCAUSE);
        expect_word("irq_mcause", 32'h8000_0007, next_csr_rdata);
        read_csr(ADDR_MEPC);
        expect_word("irq_mepc", irq_pc, next_csr_rdata);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== csr_stage.f ====
+incdir+.
csr_pkg.sv
trap_pkg.sv
csr_if.sv
csr_access.sv
csr_machine_regs.sv
trap_ctrl.sv
csr_stage_top.sv
tb_csr_stage.sv

// ==== Bender.yml ====
package:
  name: csr_stage

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - trap_pkg.sv
      - csr_if.sv
      - csr_access.sv
      - csr_machine_regs.sv
      - trap_ctrl.sv
      - csr_stage_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_stage.sv
